//--- Bender.yml
package:
  name: mem_bus

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/memBusPkg.sv
      - rtl/memReqIf.sv
      - rtl/memReqDecoder.sv
      - rtl/memReqFifo.sv
      - rtl/ramUartCtrl.sv
      - rtl/memBusTop.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tbClock.sv
      - sim/busModels.sv
      - sim/memBusTb.sv

//--- rtl/memBusPkg.sv
`include "memBus_defines.svh"

package memBusPkg;

	typedef enum logic [2:0] {
		RamRead,
		RamWrite,
		UartRead,
		UartWrite,
		UartStat
	} memOp_e;

	// Controller sequencing, one state per bus step
	typedef enum logic [4:0] {
		Idle,
		RamRd1, RamRd2, RamRd3,
		RamWr1, RamWr2, RamWr3,
		UartRd1, UartRd2, UartRd3,
		UartWr1, UartWr2, UartWr3, UartWr4, UartWr5,
		StatRd,
		Respond
	} ctrlState_e;

	typedef struct packed {
		memOp_e op;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
	} memReq_t;

endpackage

//--- rtl/memBusTop.sv
`timescale 1ns/100ps
`include "memBus_defines.svh"

module memBusTop (
	input  logic clk,
	input  logic rst,

	// Client requests
	input  logic reqValid,
	output logic reqReady,
	input  logic [`ADDR_W-1:0] reqAddr,
	input  logic [`DATA_W-1:0] reqWdata,
	input  logic reqRd,
	input  logic reqWr,

	// Client responses
	output logic rspValid,
	input  logic rspReady,
	output logic [`DATA_W-1:0] rspData,

	// SRAM
	output logic [`ADDR_W-1:0] ramAddr,
	inout  wire  [`DATA_W-1:0] ramData,
	output logic ramOe,
	output logic ramWe,
	output logic ramEn,

	// UART
	output logic uartRdn,
	output logic uartWrn,
	input  logic dataReady,
	input  logic tbre,
	input  logic tsre
);

	memReqIf decToFifo ();
	memReqIf fifoToCtrl ();

	memReqDecoder decoder (
		.clk      (clk),
		.rst      (rst),
		.reqValid (reqValid),
		.reqReady (reqReady),
		.reqAddr  (reqAddr),
		.reqWdata (reqWdata),
		.reqRd    (reqRd),
		.reqWr    (reqWr),
		.out      (decToFifo.source)
	);

	memReqFifo fifo (
		.clk (clk),
		.rst (rst),
		.in  (decToFifo.sink),
		.out (fifoToCtrl.source)
	);

	ramUartCtrl ctrl (
		.clk       (clk),
		.rst       (rst),
		.in        (fifoToCtrl.sink),
		.ramAddr   (ramAddr),
		.ramData   (ramData),
		.ramOe     (ramOe),
		.ramWe     (ramWe),
		.ramEn     (ramEn),
		.uartRdn   (uartRdn),
		.uartWrn   (uartWrn),
		.dataReady (dataReady),
		.tbre      (tbre),
		.tsre      (tsre),
		.rspValid  (rspValid),
		.rspReady  (rspReady),
		.rspData   (rspData)
	);

endmodule

//--- rtl/memBus_defines.svh
`ifndef MEM_BUS_DEFINES_SVH
`define MEM_BUS_DEFINES_SVH

// Bus widths
`define ADDR_W 16
`define DATA_W 16

// UART register map
`define UART_DATA_ADDR 16'hBF00
`define UART_STAT_ADDR 16'hBF01

// Request buffer depth, power of two
`define FIFO_DEPTH 4

// System clocks per controller step, power of two
`define STEP_DIV 4

`endif

//--- rtl/memReqDecoder.sv
`timescale 1ns/100ps
`include "memBus_defines.svh"

module memReqDecoder (
	input  logic clk,
	input  logic rst,

	input  logic reqValid,
	output logic reqReady,
	input  logic [`ADDR_W-1:0] reqAddr,
	input  logic [`DATA_W-1:0] reqWdata,
	input  logic reqRd,
	input  logic reqWr,

	memReqIf.source out
);

	logic noFlag;
	memBusPkg::memOp_e op;

	assign noFlag = !reqRd && !reqWr;

	//////////////////////////////////////////////////
	// Target decode
	//////////////////////////////////////////////////

	// Write wins when both flags are set
	always_comb begin
		if (reqWr) begin
			if (reqAddr == `UART_DATA_ADDR)
				op = memBusPkg::UartWrite;
			else
				op = memBusPkg::RamWrite;
		end else if (reqAddr == `UART_DATA_ADDR) begin
			op = memBusPkg::UartRead;
		end else if (reqAddr == `UART_STAT_ADDR) begin
			op = memBusPkg::UartStat;
		end else begin
			op = memBusPkg::RamRead;
		end
	end

	assign out.req.op    = op;
	assign out.req.addr  = reqAddr;
	assign out.req.wdata = reqWdata;

	// Flagless requests are acknowledged but never issued
	assign out.valid = reqValid && !noFlag;
	assign reqReady  = out.ready;

endmodule

//--- rtl/memReqFifo.sv
`timescale 1ns/100ps
`include "memBus_defines.svh"

module memReqFifo (
	input  logic clk,
	input  logic rst,

	memReqIf.sink   in,
	memReqIf.source out
);

	localparam int PtrW = $clog2(`FIFO_DEPTH);

	memBusPkg::memReq_t mem [`FIFO_DEPTH];

	// Extra top bit tells a full buffer from an empty one
	logic [PtrW:0] wrPtr;
	logic [PtrW:0] rdPtr;

	logic full;
	logic empty;
	logic push;
	logic pop;

	assign empty = (wrPtr == rdPtr);
	assign full  = (wrPtr[PtrW] != rdPtr[PtrW]) &&
	               (wrPtr[PtrW-1:0] == rdPtr[PtrW-1:0]);

	assign in.ready  = !full;
	assign out.valid = !empty;
	assign out.req   = mem[rdPtr[PtrW-1:0]];

	assign push = in.valid && !full;
	assign pop  = out.valid && out.ready;

	//////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr[PtrW-1:0]] <= in.req;
	end

endmodule

//--- rtl/memReqIf.sv
`timescale 1ns/100ps

// Decoded request channel with valid/ready handshake
interface memReqIf;

	memBusPkg::memReq_t req;
	logic valid;
	logic ready;

	modport source (
		output req,
		output valid,
		input  ready
	);

	modport sink (
		input  req,
		input  valid,
		output ready
	);

endinterface

//--- rtl/ramUartCtrl.sv
`timescale 1ns/100ps
`include "memBus_defines.svh"

module ramUartCtrl (
	input  logic clk,
	input  logic rst,

	memReqIf.sink in,

	// SRAM pins, strobes active low
	output logic [`ADDR_W-1:0] ramAddr,
	inout  wire  [`DATA_W-1:0] ramData,
	output logic ramOe,
	output logic ramWe,
	output logic ramEn,

	// UART pins
	output logic uartRdn,
	output logic uartWrn,
	input  logic dataReady,
	input  logic tbre,
	input  logic tsre,

	// Response channel
	output logic rspValid,
	input  logic rspReady,
	output logic [`DATA_W-1:0] rspData
);

	localparam int StepW = $clog2(`STEP_DIV);

	memBusPkg::ctrlState_e state;
	memBusPkg::ctrlState_e nextState;

	logic [StepW-1:0] stepCnt;
	logic step;
	logic drive;
	memBusPkg::memReq_t reqReg;

	//////////////////////////////////////////////////
	// Step divider and request capture
	//////////////////////////////////////////////////

	assign step = (stepCnt == StepW'(`STEP_DIV - 1));

	// New work is taken only on a step boundary in Idle
	assign in.ready = (state == memBusPkg::Idle) && step;

	always_ff @(posedge clk) begin
		if (in.valid && in.ready)
			reqReg <= in.req;
	end

	assign ramAddr  = reqReg.addr;
	assign ramData  = drive ? reqReg.wdata : 'z;
	assign rspValid = (state == memBusPkg::Respond);

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			memBusPkg::Idle: begin
				if (in.valid) begin
					case (in.req.op)
						memBusPkg::RamRead:   nextState = memBusPkg::RamRd1;
						memBusPkg::RamWrite:  nextState = memBusPkg::RamWr1;
						memBusPkg::UartRead:  nextState = memBusPkg::UartRd1;
						memBusPkg::UartWrite: nextState = memBusPkg::UartWr1;
						memBusPkg::UartStat:  nextState = memBusPkg::StatRd;
						default:              nextState = memBusPkg::Idle;
					endcase
				end
			end

			memBusPkg::RamRd1: nextState = memBusPkg::RamRd2;
			memBusPkg::RamRd2: nextState = memBusPkg::RamRd3;
			memBusPkg::RamRd3: nextState = memBusPkg::Respond;

			memBusPkg::RamWr1: nextState = memBusPkg::RamWr2;
			memBusPkg::RamWr2: nextState = memBusPkg::RamWr3;
			memBusPkg::RamWr3: nextState = memBusPkg::Respond;

			// Hold until the UART has a byte
			memBusPkg::UartRd1: begin
				if (dataReady)
					nextState = memBusPkg::UartRd2;
			end
			memBusPkg::UartRd2: nextState = memBusPkg::UartRd3;
			memBusPkg::UartRd3: nextState = memBusPkg::Respond;

			memBusPkg::UartWr1: nextState = memBusPkg::UartWr2;
			memBusPkg::UartWr2: nextState = memBusPkg::UartWr3;
			memBusPkg::UartWr3: begin
				if (tbre)
					nextState = memBusPkg::UartWr4;
			end
			memBusPkg::UartWr4: begin
				if (tsre)
					nextState = memBusPkg::UartWr5;
			end
			memBusPkg::UartWr5: nextState = memBusPkg::Respond;

			memBusPkg::StatRd: nextState = memBusPkg::Respond;

			memBusPkg::Respond: begin
				if (rspReady)
					nextState = memBusPkg::Idle;
			end

			default: nextState = memBusPkg::Idle;
		endcase
	end

	//////////////////////////////////////////////////
	// State, strobes and pin driver
	//////////////////////////////////////////////////

	// Strobes follow the state entered, so each stays put for a full step
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state   <= memBusPkg::Idle;
			stepCnt <= '0;
			ramEn   <= 1'b1;
			ramOe   <= 1'b1;
			ramWe   <= 1'b1;
			uartRdn <= 1'b1;
			uartWrn <= 1'b1;
			drive   <= 1'b0;
		end else begin
			stepCnt <= stepCnt + 1'b1;
			// Respond leaves as soon as the client takes the data
			if (step || state == memBusPkg::Respond)
				state <= nextState;
			if (step) begin
				ramEn <= !(nextState inside {memBusPkg::RamRd1, memBusPkg::RamRd2,
					memBusPkg::RamRd3, memBusPkg::RamWr1, memBusPkg::RamWr2,
					memBusPkg::RamWr3});
				ramOe <= !(nextState inside {memBusPkg::RamRd1, memBusPkg::RamRd2,
					memBusPkg::RamRd3});
				ramWe   <= (nextState != memBusPkg::RamWr2);
				uartRdn <= (nextState != memBusPkg::UartRd2);
				uartWrn <= (nextState != memBusPkg::UartWr2);
				drive <= nextState inside {memBusPkg::RamWr1, memBusPkg::RamWr2,
					memBusPkg::RamWr3, memBusPkg::UartWr1, memBusPkg::UartWr2,
					memBusPkg::UartWr3};
			end
		end
	end

	//////////////////////////////////////////////////
	// Response data
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (step) begin
			case (state)
				memBusPkg::RamRd3:
					rspData <= ramData;
				// Sampled while uartRdn is still low
				memBusPkg::UartRd2:
					rspData <= {{(`DATA_W - 8){1'b0}}, ramData[7:0]};
				memBusPkg::StatRd:
					rspData <= {{(`DATA_W - 2){1'b0}}, dataReady, tbre && tsre};
				memBusPkg::RamWr3, memBusPkg::UartWr5:
					rspData <= '0;
				default: ;
			endcase
		end
	end

endmodule

//--- sim/busModels.sv
`timescale 1ns/100ps
`include "memBus_defines.svh"

module busModels (
	input  logic clk,
	input  logic [`ADDR_W-1:0] ramAddr,
	inout  wire  [`DATA_W-1:0] ramData,
	input  logic ramOe,
	input  logic ramWe,
	input  logic ramEn,
	input  logic uartRdn,
	input  logic uartWrn,
	output logic dataReady,
	output logic tbre,
	output logic tsre
);

	logic [`DATA_W-1:0] mem [0:(1 << `ADDR_W) - 1];
	logic [7:0] txQ [$];
	logic [7:0] rxQ [$];
	logic [7:0] rxByte;

	//////////////////////////////////////////////////
	// SRAM
	//////////////////////////////////////////////////

	always @(posedge ramWe)
		if (!ramEn)
			mem[ramAddr] = ramData;

	assign ramData = (!ramEn && !ramOe) ? mem[ramAddr] : 'z;

	//////////////////////////////////////////////////
	// UART
	//////////////////////////////////////////////////

	// Only the low byte lane reaches the UART chip
	assign ramData = !uartRdn ? {{(`DATA_W - 8){1'bz}}, rxByte} : 'z;

	task automatic loadRx(input logic [7:0] b);
		rxQ.push_back(b);
	endtask

	initial begin
		tbre = 1'b1;
		tsre = 1'b1;
	end

	// Transmitter stays busy for a while after each write
	always @(posedge uartWrn) begin
		txQ.push_back(ramData[7:0]);
		tbre <= 1'b0;
		tsre <= 1'b0;
		repeat (6)
			@(posedge clk);
		tbre <= 1'b1;
		repeat (4)
			@(posedge clk);
		tsre <= 1'b1;
	end

	// Next byte arrives a few cycles after the previous one was read
	initial begin
		dataReady = 1'b0;
		rxByte = '0;
		forever begin
			while (rxQ.size() == 0)
				@(posedge clk);
			repeat (5)
				@(posedge clk);
			rxByte = rxQ.pop_front();
			dataReady <= 1'b1;
			@(negedge uartRdn);
			dataReady <= 1'b0;
			@(posedge uartRdn);
		end
	end

endmodule

//--- sim/memBusTb.sv
`timescale 1ns/100ps
`include "memBus_defines.svh"

module memBusTb;

	// Request budget, back-pressure stall and UART handshakes
	localparam int StallCycles = 8 * `FIFO_DEPTH * `STEP_DIV;
	localparam int UartSlack   = 1952;
	localparam int CycleLimit  = 30 * 16 * `STEP_DIV + StallCycles + UartSlack;

	logic clk;
	logic rst;
	logic reqValid;
	logic reqReady;
	logic [`ADDR_W-1:0] reqAddr;
	logic [`DATA_W-1:0] reqWdata;
	logic reqRd;
	logic reqWr;
	logic rspValid;
	logic rspReady;
	logic [`DATA_W-1:0] rspData;
	logic [`ADDR_W-1:0] ramAddr;
	wire  [`DATA_W-1:0] ramData;
	logic ramOe;
	logic ramWe;
	logic ramEn;
	logic uartRdn;
	logic uartWrn;
	logic dataReady;
	logic tbre;
	logic tsre;

	logic [31:0] lfsr = 32'h93aab428;
	logic [`DATA_W-1:0] rspQ [$];
	logic [`DATA_W-1:0] refMem [logic [`ADDR_W-1:0]];
	string testName;
	int testErrors;
	int cycles;
	int checks = 0;
	int errors = 0;
	int testCount = 0;

	tbClock clkGen (.clk(clk), .rst(rst));
	memBusTop UUT (.*);
	busModels models (.*);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[14:0], lfsrBit()};
		return v;
	endfunction

	//////////////////////////////////////////////////
	// Checking and bookkeeping
	//////////////////////////////////////////////////

	task automatic compareValue(input logic [`DATA_W-1:0] expVal,
		input logic [`DATA_W-1:0] actVal);
		checks++;
		assert (actVal === expVal)
		else begin
			$display("Error in %s: expected %h, actual %h", testName, expVal, actVal);
			errors++;
		end
	endtask

	task automatic verify(input bit ok, input string msg);
		checks++;
		assert (ok)
		else begin
			$display("%s: %s", testName, msg);
			errors++;
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = errors;
	endtask

	task automatic endTest();
		testCount++;
		$display("%s finished, %0d errors", testName, errors - testErrors);
	endtask

	//////////////////////////////////////////////////
	// Client side
	//////////////////////////////////////////////////

	// Each response is taken at the following rising edge
	always @(negedge clk)
		if (rst && rspValid && rspReady)
			rspQ.push_back(rspData);

	task automatic offerReq(input logic [15:0] addr, input logic [15:0] wdata,
		input logic rd, input logic wr);
		@(posedge clk);
		reqValid <= 1'b1;
		reqAddr  <= addr;
		reqWdata <= wdata;
		reqRd    <= rd;
		reqWr    <= wr;
	endtask

	task automatic finishReq();
		@(negedge clk);
		while (!reqReady)
			@(negedge clk);
		@(posedge clk);
		reqValid <= 1'b0;
	endtask

	task automatic sendReq(input logic [15:0] addr, input logic [15:0] wdata,
		input logic rd, input logic wr);
		offerReq(addr, wdata, rd, wr);
		finishReq();
	endtask

	task automatic getRsp(output logic [`DATA_W-1:0] data);
		while (rspQ.size() == 0)
			@(negedge clk);
		data = rspQ.pop_front();
	endtask

	task automatic doReq(input logic [15:0] addr, input logic [15:0] wdata,
		input logic rd, input logic wr, input logic [15:0] expVal);
		logic [`DATA_W-1:0] rsp;
		sendReq(addr, wdata, rd, wr);
		getRsp(rsp);
		compareValue(expVal, rsp);
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic sramRoundTrip();
		logic [`ADDR_W-1:0] addrs [8];
		logic [`DATA_W-1:0] data;
		startTest("sramRoundTrip");
		// Top address bit clear stays away from the UART registers
		foreach (addrs[i]) begin
			addrs[i] = randBits(15);
			data = randBits(16);
			refMem[addrs[i]] = data;
			doReq(addrs[i], data, 1'b0, 1'b1, 16'h0000);
		end
		foreach (addrs[i])
			doReq(addrs[i], 16'h0000, 1'b1, 1'b0, refMem[addrs[i]]);
		endTest();
	endtask

	task automatic uartTransmit();
		logic [7:0] sent [3];
		logic [`DATA_W-1:0] data;
		startTest("uartTransmit");
		models.txQ.delete();
		foreach (sent[i]) begin
			data = randBits(16);
			sent[i] = data[7:0];
			doReq(`UART_DATA_ADDR, data, 1'b0, 1'b1, 16'h0000);
		end
		verify(models.txQ.size() == 3, "UART model did not capture exactly three bytes");
		foreach (sent[i])
			if (i < models.txQ.size())
				compareValue({8'h00, sent[i]}, {8'h00, models.txQ[i]});
		endTest();
	endtask

	task automatic uartReceive();
		logic [7:0] rx [2];
		logic [`DATA_W-1:0] data;
		startTest("uartReceive");
		foreach (rx[i]) begin
			data = randBits(8);
			rx[i] = data[7:0];
			models.loadRx(rx[i]);
		end
		sendReq(`UART_DATA_ADDR, 16'h0000, 1'b1, 1'b0);
		sendReq(`UART_DATA_ADDR, 16'h0000, 1'b1, 1'b0);
		foreach (rx[i]) begin
			getRsp(data);
			compareValue({8'h00, rx[i]}, data);
		end
		endTest();
	endtask

	task automatic statusWord();
		logic [7:0] rx;
		logic [`DATA_W-1:0] data;
		startTest("statusWord");
		verify(!dataReady, "UART model had a byte waiting before one was loaded");
		// Nothing received, transmitter idle since the last write finished
		doReq(`UART_STAT_ADDR, 16'h0000, 1'b1, 1'b0, 16'h0001);
		data = randBits(8);
		rx = data[7:0];
		models.loadRx(rx);
		while (!dataReady)
			@(negedge clk);
		// Byte waiting, transmitter still idle
		doReq(`UART_STAT_ADDR, 16'h0000, 1'b1, 1'b0, 16'h0003);
		// Drain the waiting byte
		doReq(`UART_DATA_ADDR, 16'h0000, 1'b1, 1'b0, {8'h00, rx});
		endTest();
	endtask

	task automatic backPressure();
		logic [`ADDR_W-1:0] addrs [3];
		logic [`DATA_W-1:0] data;
		logic [`DATA_W-1:0] expQ [$];
		bit held;
		startTest("backPressure");
		@(posedge clk);
		rspReady <= 1'b0;
		foreach (addrs[i]) begin
			addrs[i] = randBits(15);
			data = randBits(16);
			refMem[addrs[i]] = data;
			expQ.push_back(16'h0000);
			sendReq(addrs[i], data, 1'b0, 1'b1);
		end
		foreach (addrs[i])
			expQ.push_back(refMem[addrs[i]]);
		sendReq(addrs[0], 16'h0000, 1'b1, 1'b0);
		sendReq(addrs[1], 16'h0000, 1'b1, 1'b0);
		// Sixth request meets a full FIFO and a controller stuck in Respond
		offerReq(addrs[2], 16'h0000, 1'b1, 1'b0);
		held = 1'b1;
		repeat (StallCycles) begin
			@(negedge clk);
			if (reqReady || rspQ.size() != 0)
				held = 1'b0;
		end
		verify(held, "reqReady was high or a response came out while rspReady was low");
		@(posedge clk);
		rspReady <= 1'b1;
		finishReq();
		foreach (expQ[i]) begin
			getRsp(data);
			compareValue(expQ[i], data);
		end
		endTest();
	endtask

	task automatic droppedRequest();
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] data;
		startTest("droppedRequest");
		addr = randBits(15);
		data = randBits(16);
		refMem[addr] = data;
		doReq(addr, data, 1'b0, 1'b1, 16'h0000);
		sendReq(addr, ~data, 1'b0, 1'b0);
		doReq(addr, 16'h0000, 1'b1, 1'b0, refMem[addr]);
		repeat (8 * `STEP_DIV)
			@(negedge clk);
		verify(rspQ.size() == 0, "a request with no flag produced a response");
		endTest();
	endtask

	//////////////////////////////////////////////////
	// Sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		reqValid = 1'b0;
		reqAddr  = '0;
		reqWdata = '0;
		reqRd    = 1'b0;
		reqWr    = 1'b0;
		rspReady = 1'b1;
		@(posedge rst);
		sramRoundTrip();
		uartTransmit();
		uartReceive();
		statusWord();
		backPressure();
		droppedRequest();
		$display("%0d tests run, %0d checks, %0d errors", testCount, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the run did not finish", CycleLimit);
		$display("Testbench failed");
		$finish;
	end

endmodule

//--- sim/tbClock.sv
`timescale 1ns/100ps

module tbClock (
	output logic clk,
	output logic rst
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		rst = 1'b0;
		repeat (4)
			@(posedge clk);
		rst <= 1'b1;
	end

endmodule

//--- src.f
+incdir+rtl
rtl/memBusPkg.sv
rtl/memReqIf.sv
rtl/memReqDecoder.sv
rtl/memReqFifo.sv
rtl/ramUartCtrl.sv
rtl/memBusTop.sv
sim/tbClock.sv
sim/busModels.sv
sim/memBusTb.sv
